// File: fetch_top.f
rtl/fetch_pkg.sv
rtl/fetch_csr_pkg.sv
rtl/fetch_pc_gen.sv
rtl/branch_predictor.sv
rtl/inst_buffer.sv
rtl/fetch_csr.sv
rtl/fetch_top.sv
tests/fetch_clk_gen.sv
tests/fetch_properties.sv
tests/fetch_tb.sv

// File: rtl/branch_predictor.sv
`timescale 1ns/100ps

module branch_predictor (
    input  logic             clk,
    input  logic             rst,
    input  fetch_pkg::addr_t lookup_addr,
    input  logic             update,
    input  fetch_pkg::addr_t update_addr,
    input  logic             update_taken,
    input  fetch_pkg::addr_t update_target,
    output logic             predict_taken,
    output fetch_pkg::addr_t predict_target
);
    import fetch_pkg::*;

    // Direct-mapped BTB storage
    logic [BTB_ENTRIES-1:0] valid_q;
    btb_tag_t               tag_mem    [BTB_ENTRIES];
    addr_t                  target_mem [BTB_ENTRIES];
    ctr_t                   ctr_mem    [BTB_ENTRIES];

    logic [BTB_IDX_W-1:0]   lk_idx;
    btb_tag_t               lk_tag;
    logic [BTB_IDX_W-1:0]   up_idx;
    btb_tag_t               up_tag;
    logic                   up_hit;
    ctr_t                   up_ctr;

    assign lk_idx = lookup_addr[LINE_OFF_W +: BTB_IDX_W];
    assign lk_tag = lookup_addr[31:BTB_TAG_LSB];
    assign up_idx = update_addr[LINE_OFF_W +: BTB_IDX_W];
    assign up_tag = update_addr[31:BTB_TAG_LSB];

    // Lookup, same cycle
    assign predict_taken  = valid_q[lk_idx] && (tag_mem[lk_idx] == lk_tag)
                            && ctr_mem[lk_idx][1];   // Counter at 2 or 3
    assign predict_target = target_mem[lk_idx];

    assign up_hit = valid_q[up_idx] && (tag_mem[up_idx] == up_tag);
    assign up_ctr = ctr_mem[up_idx];

    // Valid bits
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (update && !up_hit && update_taken) begin
            valid_q[up_idx] <= 1'b1;   // Allocate on a taken miss
        end
    end

    // Entry payload
    always_ff @(posedge clk) begin
        if (update) begin
            if (up_hit) begin
                if (update_taken) begin
                    if (up_ctr != 2'b11) begin
                        ctr_mem[up_idx] <= up_ctr + 1'b1;
                    end
                    target_mem[up_idx] <= update_target;   // Latest taken target wins
                end else if (up_ctr != 2'b00) begin
                    ctr_mem[up_idx] <= up_ctr - 1'b1;
                end
            end else if (update_taken) begin
                tag_mem[up_idx]    <= up_tag;
                target_mem[up_idx] <= update_target;
                ctr_mem[up_idx]    <= 2'b10;   // Weakly taken
            end
            // Not-taken miss leaves the entry alone
        end
    end

endmodule

// File: rtl/fetch_csr.sv
`timescale 1ns/100ps

module fetch_csr (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  fetch_csr_pkg::wb_adr_t  wb_adr,
    input  fetch_csr_pkg::wb_data_t wb_dat_w,
    input  logic                   resteer,
    input  logic                   fetch_valid,
    output fetch_csr_pkg::wb_data_t wb_dat_r,
    output logic                   wb_ack,
    output logic                   fetch_en,
    output logic                   bp_en,
    output fetch_pkg::addr_t        boot_vector
);
    import fetch_csr_pkg::*;

    logic     req;
    wb_adr_t  reg_sel;
    wb_data_t rd_data;
    wb_data_t resteer_count;
    wb_data_t line_count;

    // New access only while no ack is out
    assign req = wb_cyc & wb_stb & ~wb_ack;
    assign reg_sel = {wb_adr[3:2], 2'b00};   // Word decode, low bits ignored

    // Read mux
    always_comb begin
        rd_data = '0;
        case (reg_sel)
            REG_CTRL: begin
                rd_data[CTRL_FETCH_EN] = fetch_en;
                rd_data[CTRL_BP_EN]    = bp_en;
            end
            REG_BOOT:     rd_data = boot_vector;
            REG_RESTEERS: rd_data = resteer_count;
            REG_LINES:    rd_data = line_count;
            default:      rd_data = '0;
        endcase
    end

    // Ack and writable registers
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack      <= 1'b0;
            fetch_en    <= 1'b0;
            bp_en       <= 1'b0;
            boot_vector <= '0;
        end else begin
            wb_ack <= req;   // Exactly one cycle
            if (req && wb_we) begin
                case (reg_sel)
                    REG_CTRL: begin
                        fetch_en <= wb_dat_w[CTRL_FETCH_EN];
                        bp_en    <= wb_dat_w[CTRL_BP_EN];
                    end
                    REG_BOOT: boot_vector <= wb_dat_w;
                    default: ;   // Counters are read only, write acked and dropped
                endcase
            end
        end
    end

    // Read data, valid with the ack
    always_ff @(posedge clk) begin
        if (req) begin
            wb_dat_r <= rd_data;
        end
    end

    // Status counters, wrap at 32 bits
    always_ff @(posedge clk) begin
        if (rst) begin
            resteer_count <= '0;
            line_count    <= '0;
        end else begin
            if (resteer) resteer_count <= resteer_count + 1'b1;
            if (fetch_valid) line_count <= line_count + 1'b1;   // One per line request
        end
    end

endmodule

// File: rtl/fetch_csr_pkg.sv
package fetch_csr_pkg;

    typedef logic [31:0] wb_data_t;
    typedef logic [3:0]  wb_adr_t;   // Byte address, decoded on bits 3..2

    // Register map
    localparam wb_adr_t REG_CTRL     = 4'h0;
    localparam wb_adr_t REG_BOOT     = 4'h4;
    localparam wb_adr_t REG_RESTEERS = 4'h8;   // Read only
    localparam wb_adr_t REG_LINES    = 4'hC;   // Read only

    // Control register bits
    localparam int CTRL_FETCH_EN = 0;
    localparam int CTRL_BP_EN    = 1;

endpackage

// File: rtl/fetch_pc_gen.sv
`timescale 1ns/100ps

module fetch_pc_gen (
    input  logic             clk,
    input  logic             rst,
    input  logic             fetch_en,
    input  fetch_pkg::addr_t boot_vector,
    input  logic             stall_in,
    input  logic             ibuf_full,
    input  logic             resteer,
    input  logic             rob_taken,
    input  fetch_pkg::addr_t rob_target,
    input  logic             d1_taken,
    input  fetch_pkg::addr_t d1_target,
    input  logic             ras_taken,
    input  fetch_pkg::addr_t ras_target,
    input  logic             pred_taken,
    input  fetch_pkg::addr_t pred_target,
    output logic             fetch_valid,
    output fetch_pkg::addr_t fetch_addr,
    output logic [1:0]       fetch_offset
);
    import fetch_pkg::*;

    addr_t   pc_q;      // Full PC, word offset kept after a redirect
    logic    stall;
    pc_src_e pc_src;

    assign stall = stall_in | ibuf_full;   // Buffer back-pressure joins the external stall

    assign fetch_addr   = pc_q & ~addr_t'(LINE_BYTES - 1);   // Line aligned
    assign fetch_offset = pc_q[LINE_OFF_W-1:2];              // Word inside the line
    assign fetch_valid  = fetch_en & ~stall & ~resteer;

    // Source select, highest priority first
    always_comb begin
        if (!fetch_en) begin
            pc_src = PC_BOOT;
        end else if (resteer) begin
            if (rob_taken) begin
                pc_src = PC_ROB;
            end else if (d1_taken) begin
                pc_src = PC_D1;
            end else if (ras_taken) begin
                pc_src = PC_RAS;
            end else begin
                pc_src = PC_HOLD;   // Resteer with no taken source
            end
        end else if (stall) begin
            pc_src = PC_HOLD;
        end else if (pred_taken) begin
            pc_src = PC_PRED;
        end else begin
            pc_src = PC_SEQ;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= '0;
        end else begin
            case (pc_src)
                PC_BOOT: pc_q <= boot_vector & ~addr_t'(LINE_BYTES - 1);   // Rounded to a line
                PC_ROB:  pc_q <= rob_target;
                PC_D1:   pc_q <= d1_target;
                PC_RAS:  pc_q <= ras_target;
                PC_PRED: pc_q <= pred_target;
                PC_SEQ:  pc_q <= fetch_addr + addr_t'(LINE_BYTES);   // Next line, offset dropped
                default: pc_q <= pc_q;
            endcase
        end
    end

endmodule

// File: rtl/fetch_pkg.sv
package fetch_pkg;

    // Widths with a meaning
    typedef logic [31:0]  addr_t;     // Byte address
    typedef logic [127:0] line_t;     // One cache line
    typedef logic [31:0]  inst_t;     // One instruction word

    // Line geometry
    localparam int LINE_BYTES     = 16;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_OFF_W     = 4;   // Byte offset bits inside a line

    // BTB sizing, index sits just above the line offset
    localparam int BTB_ENTRIES = 16;
    localparam int BTB_IDX_W   = 4;   // Address bits 7..4
    localparam int BTB_TAG_LSB = LINE_OFF_W + BTB_IDX_W;

    typedef logic [23:0] btb_tag_t;   // Address bits 31..8
    typedef logic [1:0]  ctr_t;       // 2-bit saturating counter

    // Instruction buffer depth in lines
    localparam int IBUF_DEPTH = 4;

    // Next PC source
    typedef enum logic [2:0] {
        PC_HOLD,
        PC_BOOT,
        PC_ROB,
        PC_D1,
        PC_RAS,
        PC_PRED,
        PC_SEQ
    } pc_src_e;

endpackage

// File: rtl/fetch_top.sv
`timescale 1ns/100ps

module fetch_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  fetch_csr_pkg::wb_adr_t  wb_adr,
    input  fetch_csr_pkg::wb_data_t wb_dat_w,
    output fetch_csr_pkg::wb_data_t wb_dat_r,
    output logic                    wb_ack,
    input  logic                    stall_in,
    input  logic                    resteer,
    input  logic                    rob_taken,
    input  fetch_pkg::addr_t        rob_target,
    input  logic                    d1_taken,
    input  fetch_pkg::addr_t        d1_target,
    input  logic                    ras_taken,
    input  fetch_pkg::addr_t        ras_target,
    input  logic                    update_btb,
    input  fetch_pkg::addr_t        resolved_pc,
    input  fetch_pkg::addr_t        resolved_target,
    input  logic                    resolved_taken,
    output logic                    fetch_valid,
    output fetch_pkg::addr_t        fetch_addr,
    input  logic                    line_valid,
    input  fetch_pkg::line_t        line_data,
    input  logic                    inst_ready,
    output logic                    inst_valid,
    output fetch_pkg::inst_t        inst_word,
    output fetch_pkg::addr_t        inst_pc
);
    import fetch_pkg::*;

    logic       fetch_en;
    logic       bp_en;
    addr_t      boot_vector;
    logic       ibuf_full;
    logic [1:0] fetch_offset;
    logic       btb_hit;       // Raw BTB prediction
    logic       pred_taken;
    addr_t      pred_target;

    assign pred_taken = btb_hit & bp_en;   // Predictor switch from the control register

    fetch_csr csr_i (
        .clk(clk), .rst(rst),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
        .resteer(resteer), .fetch_valid(fetch_valid),
        .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .fetch_en(fetch_en), .bp_en(bp_en), .boot_vector(boot_vector)
    );

    fetch_pc_gen pc_gen_i (
        .clk(clk), .rst(rst),
        .fetch_en(fetch_en), .boot_vector(boot_vector),
        .stall_in(stall_in), .ibuf_full(ibuf_full),
        .resteer(resteer),
        .rob_taken(rob_taken), .rob_target(rob_target),
        .d1_taken(d1_taken), .d1_target(d1_target),
        .ras_taken(ras_taken), .ras_target(ras_target),
        .pred_taken(pred_taken), .pred_target(pred_target),
        .fetch_valid(fetch_valid), .fetch_addr(fetch_addr), .fetch_offset(fetch_offset)
    );

    branch_predictor bp_i (
        .clk(clk), .rst(rst),
        .lookup_addr(fetch_addr),
        .update(update_btb), .update_addr(resolved_pc),
        .update_taken(resolved_taken), .update_target(resolved_target),
        .predict_taken(btb_hit), .predict_target(pred_target)
    );

    // Any resteer empties the buffer
    inst_buffer ibuf_i (
        .clk(clk), .rst(rst), .flush(resteer),
        .fetch_valid(fetch_valid), .fetch_addr(fetch_addr), .fetch_offset(fetch_offset),
        .line_valid(line_valid), .line_data(line_data),
        .inst_ready(inst_ready), .ibuf_full(ibuf_full),
        .inst_valid(inst_valid), .inst_word(inst_word), .inst_pc(inst_pc)
    );

endmodule

// File: rtl/inst_buffer.sv
`timescale 1ns/100ps

module inst_buffer (
    input  logic             clk,
    input  logic             rst,
    input  logic             flush,
    input  logic             fetch_valid,
    input  fetch_pkg::addr_t fetch_addr,
    input  logic [1:0]       fetch_offset,
    input  logic             line_valid,
    input  fetch_pkg::line_t line_data,
    input  logic             inst_ready,
    output logic             ibuf_full,
    output logic             inst_valid,
    output fetch_pkg::inst_t inst_word,
    output fetch_pkg::addr_t inst_pc
);
    import fetch_pkg::*;

    // Request in flight, the icache answers one cycle later
    logic req_valid_q;
    addr_t req_addr_q;
    logic [1:0] req_off_q;

    // Line FIFO
    line_t line_mem [IBUF_DEPTH];
    addr_t addr_mem [IBUF_DEPTH];
    logic [1:0] word_mem [IBUF_DEPTH];   // Next word to hand out
    logic [$clog2(IBUF_DEPTH)-1:0] wr_ptr_q;
    logic [$clog2(IBUF_DEPTH)-1:0] rd_ptr_q;
    logic [$clog2(IBUF_DEPTH):0] count_q;
    logic [$clog2(IBUF_DEPTH):0] occupancy;

    logic push;
    logic pop;
    logic xfer;
    logic [1:0] cur_word;
    logic [3:0] byte_shift;
    line_t rot_line;

    assign push = line_valid & req_valid_q & ~flush;   // In-flight line dropped on flush
    assign occupancy = count_q + req_valid_q;
    assign ibuf_full = occupancy >= IBUF_DEPTH;   // Counts the line still on its way

    assign inst_valid = count_q != '0;
    assign xfer = inst_valid & inst_ready;
    assign cur_word = word_mem[rd_ptr_q];
    assign pop = xfer && (cur_word == 2'(WORDS_PER_LINE - 1));   // Last word of the line

    // Byte rotator, word index times 4 bytes
    assign byte_shift = {cur_word, 2'b00};
    assign rot_line = line_mem[rd_ptr_q] >> {byte_shift, 3'b000};
    assign inst_word = rot_line[31:0];
    assign inst_pc = addr_mem[rd_ptr_q] | {cur_word, 2'b00};

    always_ff @(posedge clk) begin
        if (rst) begin
            req_valid_q <= 1'b0;
            wr_ptr_q    <= '0;
            rd_ptr_q    <= '0;
            count_q     <= '0;
        end else begin
            req_valid_q <= fetch_valid & ~flush;
            if (flush) begin
                wr_ptr_q <= '0;
                rd_ptr_q <= '0;
                count_q  <= '0;
            end else begin
                if (push) wr_ptr_q <= wr_ptr_q + 1'b1;   // Depth is a power of two
                if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
                case ({push, pop})
                    2'b10:   count_q <= count_q + 1'b1;
                    2'b01:   count_q <= count_q - 1'b1;
                    default: count_q <= count_q;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        req_addr_q <= fetch_addr;
        req_off_q  <= fetch_offset;
        if (push) begin
            line_mem[wr_ptr_q] <= line_data;
            addr_mem[wr_ptr_q] <= req_addr_q;
            word_mem[wr_ptr_q] <= req_off_q;   // Mid-line target starts here
        end
        if (xfer && !pop) begin
            word_mem[rd_ptr_q] <= cur_word + 1'b1;   // Never the push slot, FIFO not full
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module fetch_tb \
    -f fetch_top.f -o fetch_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/fetch_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "sim passed" sim.log; then
    exit 0
fi
exit 1

// File: tests/fetch_clk_gen.sv
`timescale 1ns/100ps

module fetch_clk_gen (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        rst = 1'b1;
        repeat (2) @(posedge clk);   // Two cycles in reset
        @(negedge clk);
        rst = 1'b0;
    end

    always #20 clk = ~clk;   // 40 ns period

endmodule

// File: tests/fetch_properties.sv
`timescale 1ns/100ps

module fetch_properties (
    input logic       clk,
    input logic       rst,
    input logic       wb_ack,
    input logic       fetch_en,
    input logic       fetch_valid,
    input logic       resteer,
    input logic       inst_valid,
    input logic       push,
    input logic [2:0] count
);
    import fetch_pkg::*;

    a_ack_one_cycle: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
        else $error("wb_ack held longer than one cycle");

    a_no_fetch_when_off: assert property (@(posedge clk) disable iff (rst)
        !fetch_en |-> !fetch_valid)
        else $error("fetch_valid high with fetch disabled");

    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        push |-> count < IBUF_DEPTH)
        else $error("line pushed into a full buffer");

    a_flush_drops: assert property (@(posedge clk) disable iff (rst) resteer |=> !inst_valid)
        else $error("inst_valid still high after a resteer");

endmodule

bind fetch_top fetch_properties props_i (
    .clk(clk), .rst(rst), .wb_ack(wb_ack),
    .fetch_en(fetch_en), .fetch_valid(fetch_valid),
    .resteer(resteer), .inst_valid(inst_valid),
    .push(ibuf_i.push), .count(ibuf_i.count_q)
);

// File: tests/fetch_tb.sv
`timescale 1ns/100ps

module fetch_tb;
    import fetch_pkg::*;
    import fetch_csr_pkg::*;

    localparam int CYCLE_LIMIT = 2000;   // About four times the summed test length

    logic clk, rst;
    logic wb_cyc, wb_stb, wb_we, wb_ack;
    wb_adr_t wb_adr;
    wb_data_t wb_dat_w, wb_dat_r;
    logic stall_in, resteer, rob_taken, d1_taken, ras_taken;
    addr_t rob_target, d1_target, ras_target;
    logic update_btb, resolved_taken;
    addr_t resolved_pc, resolved_target;
    logic fetch_valid, line_valid, inst_ready, inst_valid;
    addr_t fetch_addr, inst_pc;
    line_t line_data;
    inst_t inst_word;

    integer seed = 32'hfe85_14b2;
    int cycles = 0, errors = 0, tests_run = 0, tests_failed = 0;
    string cur_test = "reset";

    // Stream model
    logic track_en = 1'b0;
    addr_t exp_pc, resteer_exp, jump_from, jump_to;
    logic jump_on = 1'b0;
    int n_inst = 0, fv_total = 0;
    int ready_mode = 0;   // 0 always ready, 1 random gaps, 2 held low
    logic pend_valid = 1'b0;
    addr_t pend_addr;

    fetch_clk_gen clk_gen_i (.clk(clk), .rst(rst));

    fetch_top dut_i (
        .clk(clk), .rst(rst),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .stall_in(stall_in), .resteer(resteer),
        .rob_taken(rob_taken), .rob_target(rob_target),
        .d1_taken(d1_taken), .d1_target(d1_target),
        .ras_taken(ras_taken), .ras_target(ras_target),
        .update_btb(update_btb), .resolved_pc(resolved_pc),
        .resolved_target(resolved_target), .resolved_taken(resolved_taken),
        .fetch_valid(fetch_valid), .fetch_addr(fetch_addr),
        .line_valid(line_valid), .line_data(line_data),
        .inst_ready(inst_ready), .inst_valid(inst_valid),
        .inst_word(inst_word), .inst_pc(inst_pc)
    );

    // Every word of a line equals its own address
    function automatic line_t make_line(input addr_t a);
        line_t l;
        for (int i = 0; i < WORDS_PER_LINE; i++) l[32*i +: 32] = a + addr_t'(4 * i);
        return l;
    endfunction

    function automatic addr_t next_pc(input addr_t pc);
        if (jump_on && pc == jump_from + 32'd12) return jump_to;   // Taken after word 3
        return pc + 32'd4;
    endfunction

    task automatic check_addr(input string what, input addr_t exp, input addr_t act);
        if (exp !== act) begin
            errors++;
            $display("Fail %s %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_inst(input string what, input inst_t exp, input inst_t act);
        if (exp !== act) begin
            errors++;
            $display("Fail %s %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_reg(input string what, input wb_data_t exp, input wb_data_t act);
        if (exp !== act) begin
            errors++;
            $display("Fail %s %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    // Icache model answers one cycle after the request
    always @(posedge clk) begin
        pend_valid <= fetch_valid & ~rst;
        pend_addr  <= fetch_addr;
    end

    always @(negedge clk) begin
        line_valid = pend_valid;
        line_data  = make_line(pend_addr);
        case (ready_mode)
            1: inst_ready = ($random(seed) & 3) != 0;
            2: inst_ready = 1'b0;
            default: inst_ready = 1'b1;
        endcase
    end

    // Watchdog and stream checker
    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles in %s, the stream stopped", cycles, cur_test);
            $display("sim failed");
            $finish;
        end else if (!rst) begin
            if (fetch_valid) fv_total++;
            if (fetch_valid && fetch_addr[3:0] !== 4'h0) begin
                errors++;
                $display("%s: fetch_addr %h is not line aligned", cur_test, fetch_addr);
            end
            if (track_en && inst_valid && inst_ready) begin
                check_addr("inst_pc", exp_pc, inst_pc);
                check_inst("inst_word", inst_t'(exp_pc), inst_word);
                n_inst++;
                exp_pc = next_pc(exp_pc);
            end
            if (track_en && resteer) exp_pc = resteer_exp;   // Flush takes effect here
        end
    end

    task automatic wb_access(input logic we, input wb_adr_t adr, input wb_data_t wdata,
                             output wb_data_t rdata);
        @(negedge clk);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = adr;
        wb_dat_w = wdata;
        @(negedge clk);
        while (!wb_ack) @(negedge clk);
        rdata = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        @(negedge clk);
        if (wb_ack) begin
            errors++;
            $display("%s: ack stayed high for more than one cycle", cur_test);
        end
    endtask

    task automatic wb_write(input wb_adr_t adr, input wb_data_t data);
        wb_data_t unused;
        wb_access(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input wb_adr_t adr, output wb_data_t data);
        wb_access(1'b0, adr, '0, data);
    endtask

    task automatic wait_insts(input int n);
        while (n_inst < n) @(negedge clk);
    endtask

    task automatic start_stream(input addr_t boot, input wb_data_t ctrl);
        wb_write(REG_BOOT, boot);
        exp_pc = boot;
        n_inst = 0;
        track_en = 1'b1;
        wb_write(REG_CTRL, ctrl);
    endtask

    // Fetch off, then an empty resteer clears the buffer
    task automatic stop_fetch();
        track_en = 1'b0;
        wb_write(REG_CTRL, '0);
        @(negedge clk);
        resteer = 1'b1;
        @(negedge clk);
        resteer = 1'b0;
    endtask

    task automatic do_resteer(input logic rob, input logic d1, input logic ras,
                              input addr_t base, input addr_t exp);
        @(negedge clk);
        resteer = 1'b1;
        rob_taken = rob;
        d1_taken = d1;
        ras_taken = ras;
        rob_target = base + 32'h100;
        d1_target = base + 32'h208;   // Mid-line
        ras_target = base + 32'h304;
        resteer_exp = exp;
        @(negedge clk);
        resteer = 1'b0;
        rob_taken = 1'b0;
        d1_taken = 1'b0;
        ras_taken = 1'b0;
        wait_insts(n_inst + 6);
    endtask

    task automatic update_branch(input addr_t pc, input addr_t target, input logic taken);
        @(negedge clk);
        update_btb = 1'b1;
        resolved_pc = pc;
        resolved_target = target;
        resolved_taken = taken;
        @(negedge clk);
        update_btb = 1'b0;
    endtask

    task automatic end_test(input int err_before);
        tests_run++;
        if (errors != err_before) begin
            tests_failed++;
            $display("%s: %0d errors", cur_test, errors - err_before);
        end else begin
            $display("%s: ok", cur_test);
        end
    endtask

    function automatic addr_t rand_boot();
        addr_t b;
        b = $random(seed);
        return b & 32'h000f_fff0;   // Line aligned, away from the top of memory
    endfunction

    task automatic register_access();
        int e0;
        wb_data_t rd;
        e0 = errors;
        cur_test = "registers";
        wb_write(REG_CTRL, 32'h2);
        wb_read(REG_CTRL, rd);
        check_reg("ctrl", 32'h2, rd);
        wb_write(REG_BOOT, 32'h1234_5670);
        wb_read(REG_BOOT, rd);
        check_reg("boot", 32'h1234_5670, rd);
        wb_write(REG_LINES, 32'hffff);   // Read only
        wb_read(REG_LINES, rd);
        check_reg("lines", wb_data_t'(fv_total), rd);
        wb_write(REG_CTRL, '0);
        end_test(e0);
    endtask

    task automatic sequential_fetch();
        int e0;
        wb_data_t rd;
        e0 = errors;
        cur_test = "sequential";
        ready_mode = 1;
        start_stream(rand_boot(), 32'h1);
        wb_read(REG_CTRL, rd);
        check_reg("ctrl", 32'h1, rd);
        wait_insts(24);
        ready_mode = 2;
        repeat (20) @(negedge clk);   // Buffer fills and back-pressures
        ready_mode = 1;
        wait_insts(64);
        ready_mode = 0;
        stop_fetch();
        end_test(e0);
    endtask

    task automatic resteer_priority();
        int e0;
        addr_t b;
        wb_data_t r0, r1;
        e0 = errors;
        cur_test = "resteer";
        b = rand_boot();
        wb_read(REG_RESTEERS, r0);
        start_stream(b, 32'h1);
        wait_insts(6);
        do_resteer(1'b1, 1'b0, 1'b0, b, b + 32'h100);
        do_resteer(1'b1, 1'b1, 1'b1, b, b + 32'h100);
        do_resteer(1'b0, 1'b1, 1'b1, b, b + 32'h208);
        do_resteer(1'b0, 1'b0, 1'b1, b, b + 32'h304);
        wb_read(REG_RESTEERS, r1);
        check_reg("resteer count", 32'd4, r1 - r0);
        stop_fetch();
        end_test(e0);
    endtask

    task automatic branch_prediction();
        int e0;
        addr_t b;
        e0 = errors;
        cur_test = "prediction";
        b = rand_boot();
        jump_from = b + 32'h40;
        jump_to = b + 32'h200;
        update_branch(jump_from, jump_to, 1'b1);
        jump_on = 1'b1;
        start_stream(b, 32'h3);
        wait_insts(30);
        stop_fetch();
        jump_on = 1'b0;
        start_stream(b, 32'h1);   // Predictor off so the stream stays sequential
        wait_insts(30);
        stop_fetch();
        update_branch(jump_from, jump_to, 1'b0);
        update_branch(jump_from, jump_to, 1'b0);
        start_stream(b, 32'h3);
        wait_insts(30);
        stop_fetch();
        end_test(e0);
    endtask

    task automatic stall_freeze();
        int e0, fv0, n0;
        wb_data_t l0, l1;
        e0 = errors;
        cur_test = "stall";
        start_stream(rand_boot(), 32'h1);
        wait_insts(8);
        @(negedge clk);
        stall_in = 1'b1;
        fv0 = fv_total;
        repeat (2) @(negedge clk);   // Last request comes back
        while (inst_valid) @(negedge clk);   // Buffer drains
        n0 = n_inst;
        repeat (20) @(negedge clk);
        check_reg("fetches while stalled", wb_data_t'(fv0), wb_data_t'(fv_total));
        check_reg("words while stalled", wb_data_t'(n0), wb_data_t'(n_inst));
        wb_read(REG_LINES, l0);
        fv0 = fv_total;
        stall_in = 1'b0;
        repeat (30) @(negedge clk);
        stall_in = 1'b1;
        repeat (3) @(negedge clk);
        wb_read(REG_LINES, l1);
        check_reg("line count", wb_data_t'(fv_total - fv0), l1 - l0);
        stall_in = 1'b0;
        stop_fetch();
        end_test(e0);
    endtask

    initial begin
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        stall_in = 1'b0;
        resteer = 1'b0;
        rob_taken = 1'b0;
        d1_taken = 1'b0;
        ras_taken = 1'b0;
        rob_target = '0;
        d1_target = '0;
        ras_target = '0;
        update_btb = 1'b0;
        resolved_pc = '0;
        resolved_target = '0;
        resolved_taken = 1'b0;
        line_valid = 1'b0;
        line_data = '0;
        inst_ready = 1'b0;
        exp_pc = '0;
        resteer_exp = '0;
        jump_from = '0;
        jump_to = '0;
        @(negedge clk);
        while (rst) @(negedge clk);
        register_access();
        sequential_fetch();
        resteer_priority();
        branch_prediction();
        stall_freeze();
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
